/* hw/coreTop.sv */
module coreTop (
    input  logic               clk,
    input  logic               rst,
    input  logic               instValid,
    input  rvPkg::fetchPacket  instData,
    input  logic               resCredit,
    output logic               instCredit,
    output logic               resValid,
    output rvPkg::resultPacket resData
);
    logic               headValid;
    rvPkg::fetchPacket  head;
    logic               pop;
    logic               issue;
    logic               issueOk;
    rvPkg::decodedOp    dec;
    logic               decValid;
    logic [4:0]         rs1;
    logic [4:0]         rs2;
    logic [31:0]        rd1Data;
    logic [31:0]        rd2Data;
    rvPkg::resultPacket exRes;
    logic               exValid;
    logic               we;
    logic [4:0]         wrAddr;
    logic [31:0]        wrData;

    creditFifo #(
        .Payload(rvPkg::fetchPacket),
        .Depth  (rvPkg::InDepth)
    ) inQueue (
        .clk         (clk),
        .rst         (rst),
        .push        (instValid),
        .pushData    (instData),
        .pop         (pop),
        .popValid    (headValid),
        .popData     (head),
        .creditReturn(instCredit),
        .full        ()
    );

    instDecoder decoder (
        .clk      (clk),
        .rst      (rst),
        .headValid(headValid),
        .head     (head),
        .issueOk  (issueOk),
        .pop      (pop),
        .issue    (issue),
        .dec      (dec),
        .decValid (decValid)
    );

    regFile regs (
        .clk    (clk),
        .rst    (rst),
        .rs1    (rs1),
        .rs2    (rs2),
        .we     (we),
        .wrAddr (wrAddr),
        .wrData (wrData),
        .rd1Data(rd1Data),
        .rd2Data(rd2Data)
    );

    intExecute execute (
        .clk     (clk),
        .rst     (rst),
        .dec     (dec),
        .decValid(decValid),
        .rd1Data (rd1Data),
        .rd2Data (rd2Data),
        .fwdEn   (we),
        .fwdRd   (wrAddr),
        .fwdData (wrData),
        .rs1     (rs1),
        .rs2     (rs2),
        .res     (exRes),
        .resValid(exValid)
    );

    resultStage result (
        .clk      (clk),
        .rst      (rst),
        .res      (exRes),
        .resValid (exValid),
        .issue    (issue),
        .resCredit(resCredit),
        .issueOk  (issueOk),
        .we       (we),
        .wrAddr   (wrAddr),
        .wrData   (wrData),
        .outValid (resValid),
        .outData  (resData)
    );

endmodule

/* hw/creditFifo.sv */
module creditFifo #(
    parameter type Payload = logic [31:0],
    parameter int  Depth   = 4
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   push,
    input  Payload pushData,
    input  logic   pop,
    output logic   popValid,
    output Payload popData,
    output logic   creditReturn,
    output logic   full
);
    Payload                      mem [Depth];
    logic [$clog2(Depth)-1:0]    head;
    logic [$clog2(Depth)-1:0]    tail;
    logic [$clog2(Depth+1)-1:0]  count;

    assign popValid = (count != '0);
    assign full     = (count == $bits(count)'(Depth));
    assign popData  = mem[head];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[tail] <= pushData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            creditReturn <= 1'b0;
        end else begin
            // Each slot freed by a pop goes back to the producer one cycle later
            creditReturn <= pop;
            if (push) begin
                tail <= (tail == $bits(tail)'(Depth - 1)) ? '0 : tail + 1'b1;
            end
            if (pop) begin
                head <= (head == $bits(head)'(Depth - 1)) ? '0 : head + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // The producer holds no credit for a full queue
    noOverflow: assert property (@(posedge clk) disable iff (rst) !(push && full));
    noUnderflow: assert property (@(posedge clk) disable iff (rst) !(pop && !popValid));

endmodule

/* hw/instDecoder.sv */
module instDecoder (
    input  logic              clk,
    input  logic              rst,
    input  logic              headValid,
    input  rvPkg::fetchPacket head,
    input  logic              issueOk,
    output logic              pop,
    output logic              issue,
    output rvPkg::decodedOp   dec,
    output logic              decValid
);
    logic [31:0] inst;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [3:0]  funct;
    logic [31:0] imm;
    rvPkg::aluOp op;

    assign inst   = head.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct  = {inst[30], inst[14:12]};

    // Every popped instruction already owns a slot in the result stage
    assign pop   = headValid && issueOk;
    assign issue = pop;

    always_comb begin
        case (opcode)
            7'b0110111, 7'b0010111: imm = {inst[31:12], 12'b0};
            7'b1101111: imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            7'b1100011: imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            7'b1100111, 7'b0010011, 7'b0000011: imm = {{21{inst[31]}}, inst[30:20]};
            7'b0100011: imm = {{21{inst[31]}}, inst[30:25], inst[11:7]};
            default: imm = '0;
        endcase
    end

    always_comb begin
        op = rvPkg::opNop;
        case (opcode)
            7'b0110111: op = rvPkg::opLui;
            7'b0010111: op = rvPkg::opAuipc;
            7'b1101111: op = rvPkg::opJal;
            7'b1100111: op = rvPkg::opJalr;
            7'b1100011: begin
                case (funct3)
                    3'b000: op = rvPkg::opBeq;
                    3'b001: op = rvPkg::opBne;
                    3'b100: op = rvPkg::opBlt;
                    3'b101: op = rvPkg::opBge;
                    3'b110: op = rvPkg::opBltu;
                    3'b111: op = rvPkg::opBgeu;
                    default: op = rvPkg::opNop;
                endcase
            end
            7'b0000011: begin
                case (funct3)
                    3'b000: op = rvPkg::opLb;
                    3'b001: op = rvPkg::opLh;
                    3'b010: op = rvPkg::opLw;
                    3'b100: op = rvPkg::opLbu;
                    3'b101: op = rvPkg::opLhu;
                    default: op = rvPkg::opNop;
                endcase
            end
            7'b0100011: begin
                case (funct3)
                    3'b000: op = rvPkg::opSb;
                    3'b001: op = rvPkg::opSh;
                    3'b010: op = rvPkg::opSw;
                    default: op = rvPkg::opNop;
                endcase
            end
            7'b0010011: begin
                // Bit 30 is part of the immediate except for the right shifts
                case (funct)
                    4'b0000, 4'b1000: op = rvPkg::opAddi;
                    4'b0010, 4'b1010: op = rvPkg::opSlti;
                    4'b0011, 4'b1011: op = rvPkg::opSltiu;
                    4'b0100, 4'b1100: op = rvPkg::opXori;
                    4'b0110, 4'b1110: op = rvPkg::opOri;
                    4'b0111, 4'b1111: op = rvPkg::opAndi;
                    4'b0001: op = rvPkg::opSlli;
                    4'b0101: op = rvPkg::opSrli;
                    4'b1101: op = rvPkg::opSrai;
                    default: op = rvPkg::opNop;
                endcase
            end
            7'b0110011: begin
                if ({inst[31], inst[29:25]} == 6'b0) begin
                    case (funct)
                        4'b0000: op = rvPkg::opAdd;
                        4'b1000: op = rvPkg::opSub;
                        4'b0001: op = rvPkg::opSll;
                        4'b0010: op = rvPkg::opSlt;
                        4'b0011: op = rvPkg::opSltu;
                        4'b0100: op = rvPkg::opXor;
                        4'b0101: op = rvPkg::opSrl;
                        4'b1101: op = rvPkg::opSra;
                        4'b0110: op = rvPkg::opOr;
                        4'b0111: op = rvPkg::opAnd;
                        default: op = rvPkg::opNop;
                    endcase
                end
            end
            default: op = rvPkg::opNop;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            decValid <= 1'b0;
        end else begin
            decValid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            dec.op  <= op;
            dec.rd  <= inst[11:7];
            dec.rs1 <= inst[19:15];
            dec.rs2 <= inst[24:20];
            dec.imm <= imm;
            dec.pc  <= head.pc;
            dec.pd  <= head.pd;
        end
    end

endmodule

/* hw/intExecute.sv */
module intExecute (
    input  logic               clk,
    input  logic               rst,
    input  rvPkg::decodedOp    dec,
    input  logic               decValid,
    input  logic [31:0]        rd1Data,
    input  logic [31:0]        rd2Data,
    input  logic               fwdEn,
    input  logic [4:0]         fwdRd,
    input  logic [31:0]        fwdData,
    output logic [4:0]         rs1,
    output logic [4:0]         rs2,
    output rvPkg::resultPacket res,
    output logic               resValid
);
    logic [31:0]        srcA;
    logic [31:0]        srcB;
    logic [31:0]        opB;
    logic [4:0]         shamt;
    rvPkg::resultPacket nxt;

    assign rs1 = dec.rs1;
    assign rs2 = dec.rs2;

    // The producer right ahead has not reached the register file yet
    assign srcA = (fwdEn && fwdRd != 5'd0 && fwdRd == dec.rs1) ? fwdData : rd1Data;
    assign srcB = (fwdEn && fwdRd != 5'd0 && fwdRd == dec.rs2) ? fwdData : rd2Data;

    // Register forms sit at the end of the operation list
    assign opB   = (dec.op >= rvPkg::opAdd) ? srcB : dec.imm;
    assign shamt = opB[4:0];

    always_comb begin
        nxt      = '0;
        nxt.kind = rvPkg::rkAlu;
        nxt.pc   = dec.pc;
        nxt.rd   = dec.rd;
        nxt.addr = dec.pc + dec.imm;
        case (dec.op)
            rvPkg::opLui: nxt.value = dec.imm;
            rvPkg::opAuipc: nxt.value = dec.pc + dec.imm;
            rvPkg::opJal, rvPkg::opJalr: begin
                nxt.kind  = rvPkg::rkJump;
                nxt.value = dec.pc + 32'd4;
                nxt.taken = 1'b1;
                if (dec.op == rvPkg::opJalr) begin
                    nxt.addr = (srcA + dec.imm) & ~32'd1;
                end
            end
            rvPkg::opBeq, rvPkg::opBne, rvPkg::opBlt,
            rvPkg::opBge, rvPkg::opBltu, rvPkg::opBgeu: begin
                nxt.kind = rvPkg::rkBranch;
                case (dec.op)
                    rvPkg::opBeq: nxt.taken = (srcA == srcB);
                    rvPkg::opBne: nxt.taken = (srcA != srcB);
                    rvPkg::opBlt: nxt.taken = ($signed(srcA) < $signed(srcB));
                    rvPkg::opBge: nxt.taken = ($signed(srcA) >= $signed(srcB));
                    rvPkg::opBltu: nxt.taken = (srcA < srcB);
                    default: nxt.taken = (srcA >= srcB);
                endcase
            end
            rvPkg::opLb, rvPkg::opLh, rvPkg::opLw, rvPkg::opLbu, rvPkg::opLhu: begin
                nxt.kind = rvPkg::rkLoad;
                nxt.addr = srcA + dec.imm;
            end
            rvPkg::opSb, rvPkg::opSh, rvPkg::opSw: begin
                nxt.kind  = rvPkg::rkStore;
                nxt.addr  = srcA + dec.imm;
                nxt.value = srcB;
            end
            rvPkg::opAddi, rvPkg::opAdd: nxt.value = srcA + opB;
            rvPkg::opSub: nxt.value = srcA - opB;
            rvPkg::opSlti, rvPkg::opSlt: nxt.value = {31'b0, $signed(srcA) < $signed(opB)};
            rvPkg::opSltiu, rvPkg::opSltu: nxt.value = {31'b0, srcA < opB};
            rvPkg::opXori, rvPkg::opXor: nxt.value = srcA ^ opB;
            rvPkg::opOri, rvPkg::opOr: nxt.value = srcA | opB;
            rvPkg::opAndi, rvPkg::opAnd: nxt.value = srcA & opB;
            rvPkg::opSlli, rvPkg::opSll: nxt.value = srcA << shamt;
            rvPkg::opSrli, rvPkg::opSrl: nxt.value = srcA >> shamt;
            rvPkg::opSrai, rvPkg::opSra: nxt.value = $signed(srcA) >>> shamt;
            default: nxt.kind = rvPkg::rkIllegal;
        endcase
        nxt.writeEn = (nxt.kind == rvPkg::rkAlu || nxt.kind == rvPkg::rkJump)
                      && dec.rd != 5'd0;
        nxt.mispredict = (nxt.taken != dec.pd);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resValid <= 1'b0;
        end else begin
            resValid <= decValid;
        end
    end

    always_ff @(posedge clk) begin
        if (decValid) begin
            res <= nxt;
        end
    end

endmodule

/* hw/regFile.sv */
module regFile (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic        we,
    input  logic [4:0]  wrAddr,
    input  logic [31:0] wrData,
    output logic [31:0] rd1Data,
    output logic [31:0] rd2Data
);
    // x0 has no storage
    logic [31:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wrAddr != 5'd0) begin
            regs[wrAddr] <= wrData;
        end
    end

    assign rd1Data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rd2Data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

/* hw/resultStage.sv */
module resultStage (
    input  logic               clk,
    input  logic               rst,
    input  rvPkg::resultPacket res,
    input  logic               resValid,
    input  logic               issue,
    input  logic               resCredit,
    output logic               issueOk,
    output logic               we,
    output logic [4:0]         wrAddr,
    output logic [31:0]        wrData,
    output logic               outValid,
    output rvPkg::resultPacket outData
);
    logic                                  queued;
    logic                                  send;
    logic [$clog2(rvPkg::OutCredits+1)-1:0] credits;
    logic [$clog2(rvPkg::OutDepth+1)-1:0]   reserved;

    // The write port doubles as the bypass into execute
    assign we     = resValid && res.writeEn && res.rd != 5'd0;
    assign wrAddr = res.rd;
    assign wrData = res.value;

    assign send     = queued && credits != '0;
    assign outValid = send;
    assign issueOk  = reserved < $bits(reserved)'(rvPkg::OutDepth);

    creditFifo #(
        .Payload(rvPkg::resultPacket),
        .Depth  (rvPkg::OutDepth)
    ) outQueue (
        .clk         (clk),
        .rst         (rst),
        .push        (resValid),
        .pushData    (res),
        .pop         (send),
        .popValid    (queued),
        .popData     (outData),
        .creditReturn(),
        .full        ()
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            credits  <= $bits(credits)'(rvPkg::OutCredits);
            reserved <= '0;
        end else begin
            case ({send, resCredit})
                2'b10: credits <= credits - 1'b1;
                2'b01: credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
            // A slot is held from issue until its packet leaves
            case ({issue, send})
                2'b10: reserved <= reserved + 1'b1;
                2'b01: reserved <= reserved - 1'b1;
                default: reserved <= reserved;
            endcase
        end
    end

    creditBound: assert property (@(posedge clk) disable iff (rst)
        credits <= $bits(credits)'(rvPkg::OutCredits));
    slotBound: assert property (@(posedge clk) disable iff (rst)
        reserved <= $bits(reserved)'(rvPkg::OutDepth));

endmodule

/* hw/rvPkg.sv */
package rvPkg;

    // Input queue depth, also the credit count upstream starts with
    localparam int InDepth = 4;

    // Output queue depth, which bounds the reserved result slots
    localparam int OutDepth = 4;

    // Credits granted by the downstream consumer after reset
    localparam int OutCredits = 4;

    // Every operation the decoder can produce, opNop for anything unrecognized
    typedef enum logic [5:0] {
        opNop,
        opLui, opAuipc, opJal, opJalr,
        opBeq, opBne, opBlt, opBge, opBltu, opBgeu,
        opLb, opLh, opLw, opLbu, opLhu,
        opSb, opSh, opSw,
        opAddi, opSlti, opSltiu, opXori, opOri, opAndi,
        opSlli, opSrli, opSrai,
        opAdd, opSub, opSll, opSlt, opSltu,
        opXor, opSrl, opSra, opOr, opAnd
    } aluOp;

    typedef enum logic [2:0] {
        rkAlu,
        rkBranch,
        rkJump,
        rkLoad,
        rkStore,
        rkIllegal
    } resultKind;

    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] pc;
        logic        pd;
    } fetchPacket;

    typedef struct packed {
        aluOp        op;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;
        logic [31:0] pc;
        logic        pd;
    } decodedOp;

    // value holds the ALU result, the link address or the store data,
    // addr holds the branch or jump target or the memory address
    typedef struct packed {
        resultKind   kind;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] value;
        logic [31:0] addr;
        logic        writeEn;
        logic        taken;
        logic        mispredict;
    } resultPacket;

endpackage

/* project.f */
hw/rvPkg.sv
hw/creditFifo.sv
hw/instDecoder.sv
hw/regFile.sv
hw/intExecute.sv
hw/resultStage.sv
hw/coreTop.sv
tests/coreChecker.sv
tests/coreTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds and runs the core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module coreTb -o coreSim

./obj_dir/coreSim | tee sim.log

grep -q "TESTBENCH PASSED" sim.log
echo "Simulation passed"

/* tests/coreChecker.sv */
module coreChecker (
    input  logic               clk,
    input  logic               rst,
    input  logic               instValid,
    input  logic               instCredit,
    input  logic               resValid,
    input  logic               resCredit,
    input  logic               holding,
    input  logic               expValid,
    input  rvPkg::resultPacket expData,
    input  rvPkg::resultPacket resData,
    output int                 errors,
    output int                 checked
);
    timeunit 1ns;
    timeprecision 1ps;

    rvPkg::resultPacket expQ[$];
    int                 credits;
    int                 outstanding;
    logic               wasHolding;

    function automatic bit fieldMatches(int idx, string name, logic [31:0] expV,
                                        logic [31:0] actV);
        if (expV !== actV) begin
            $display("** Error test %0d: %s expected %h got %h", idx, name, expV, actV);
            return 1'b0;
        end
        return 1'b1;
    endfunction

    always @(posedge clk) begin
        rvPkg::resultPacket e;
        bit ok;
        if (rst) begin
            credits = rvPkg::OutCredits;
            outstanding = 0;
            wasHolding = 1'b0;
            errors = 0;
            checked = 0;
        end else begin
            // Withheld credits must all be used up before they come back
            if (wasHolding && !holding && credits != 0) begin
                $display("Results stayed queued although the downstream still had credits");
                errors++;
            end
            wasHolding = holding;
            if (expValid) begin
                expQ.push_back(expData);
            end
            if (instValid) outstanding++;
            if (instCredit) outstanding--;
            if (outstanding < 0) begin
                $display("An input credit came back with no instruction in the queue");
                errors++;
            end
            if (resValid) begin
                if (credits == 0) begin
                    $display("A result was sent while the downstream held no credit");
                    errors++;
                end
                if (expQ.size() == 0) begin
                    $display("A result arrived with no instruction outstanding");
                    errors++;
                end else begin
                    e = expQ.pop_front();
                    ok = 1'b1;
                    ok = fieldMatches(checked, "kind", 32'(e.kind), 32'(resData.kind)) & ok;
                    ok = fieldMatches(checked, "pc", e.pc, resData.pc) & ok;
                    ok = fieldMatches(checked, "writeEn", 32'(e.writeEn),
                                      32'(resData.writeEn)) & ok;
                    ok = fieldMatches(checked, "taken", 32'(e.taken), 32'(resData.taken)) & ok;
                    ok = fieldMatches(checked, "mispredict", 32'(e.mispredict),
                                      32'(resData.mispredict)) & ok;
                    // Fields that carry no meaning for a kind are left unchecked
                    if (e.kind inside {rvPkg::rkAlu, rvPkg::rkJump, rvPkg::rkLoad}) begin
                        ok = fieldMatches(checked, "rd", 32'(e.rd), 32'(resData.rd)) & ok;
                    end
                    if (e.kind inside {rvPkg::rkAlu, rvPkg::rkJump, rvPkg::rkStore}) begin
                        ok = fieldMatches(checked, "value", e.value, resData.value) & ok;
                    end
                    if (e.kind inside {rvPkg::rkBranch, rvPkg::rkJump, rvPkg::rkLoad,
                                       rvPkg::rkStore}) begin
                        ok = fieldMatches(checked, "addr", e.addr, resData.addr) & ok;
                    end
                    if (ok) begin
                        $display("Test %0d pc %h: ok", checked, resData.pc);
                    end else begin
                        $display("Test %0d pc %h: mismatch", checked, resData.pc);
                        errors++;
                    end
                    checked++;
                end
                credits--;
            end
            if (resCredit) credits++;
        end
    end

endmodule

/* tests/coreTb.sv */
module coreTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NumTests = 35;

    logic               clk;
    logic               rst;
    logic               instValid;
    rvPkg::fetchPacket  instData;
    logic               resCredit;
    logic               instCredit;
    logic               resValid;
    rvPkg::resultPacket resData;
    logic               expValid;
    rvPkg::resultPacket expData;
    logic               holding;

    logic [31:0]        instArr [NumTests];
    logic               pdArr [NumTests];
    rvPkg::resultPacket expArr [NumTests];
    int nEntries = 0;
    int sentInst = 0;
    int creditsGot = 0;
    int resultsSeen = 0;
    int creditsReturned = 0;
    int errors;
    int checked;

    coreTop UUT (
        .clk       (clk),
        .rst       (rst),
        .instValid (instValid),
        .instData  (instData),
        .resCredit (resCredit),
        .instCredit(instCredit),
        .resValid  (resValid),
        .resData   (resData)
    );

    coreChecker scoreboard (
        .clk       (clk),
        .rst       (rst),
        .instValid (instValid),
        .instCredit(instCredit),
        .resValid  (resValid),
        .resCredit (resCredit),
        .holding   (holding),
        .expValid  (expValid),
        .expData   (expData),
        .resData   (resData),
        .errors    (errors),
        .checked   (checked)
    );

    function automatic logic [31:0] encI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] encR(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] encS(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] encB(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] encU(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] encJ(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    // Entries sit at consecutive pcs starting at 0x100
    task automatic addEntry(logic [31:0] inst, logic pd, rvPkg::resultKind kind,
                            logic [4:0] rd, logic [31:0] value, logic [31:0] addr,
                            logic we, logic taken);
        rvPkg::resultPacket e;
        e.kind = kind;
        e.pc = 32'h100 + 32'(4 * nEntries);
        e.rd = rd;
        e.value = value;
        e.addr = addr;
        e.writeEn = we;
        e.taken = taken;
        e.mispredict = taken ^ pd;
        instArr[nEntries] = inst;
        pdArr[nEntries] = pd;
        expArr[nEntries] = e;
        nEntries++;
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        if (!rst) begin
            if (instCredit) creditsGot++;
            if (resValid) resultsSeen++;
        end
    end

    initial begin
        void'($urandom(79));
        rst = 1'b1;
        instValid = 1'b0;
        instData = '0;
        expValid = 1'b0;
        expData = '0;

        // Dependent ALU chain
        addEntry(encI(12'd5, 5'd0, 3'd0, 5'd1, 7'h13), 0, rvPkg::rkAlu, 5'd1, 32'd5, 0, 1, 0);
        addEntry(encR(7'h00, 5'd1, 5'd1, 3'd0, 5'd2), 0, rvPkg::rkAlu, 5'd2, 32'd10, 0, 1, 0);
        addEntry(encR(7'h20, 5'd1, 5'd2, 3'd0, 5'd3), 0, rvPkg::rkAlu, 5'd3, 32'd5, 0, 1, 0);
        addEntry(encI(12'd3, 5'd3, 3'd1, 5'd4, 7'h13), 0, rvPkg::rkAlu, 5'd4, 32'h28, 0, 1, 0);
        addEntry(encI(12'd2, 5'd4, 3'd5, 5'd5, 7'h13), 0, rvPkg::rkAlu, 5'd5, 32'h0a, 0, 1, 0);
        addEntry(encI(12'hff0, 5'd0, 3'd0, 5'd6, 7'h13), 0, rvPkg::rkAlu, 5'd6, 32'hfffffff0,
                 0, 1, 0);
        addEntry(encI(12'h402, 5'd6, 3'd5, 5'd7, 7'h13), 0, rvPkg::rkAlu, 5'd7, 32'hfffffffc,
                 0, 1, 0);
        addEntry(encR(7'h00, 5'd1, 5'd7, 3'd2, 5'd8), 0, rvPkg::rkAlu, 5'd8, 32'd1, 0, 1, 0);
        addEntry(encR(7'h00, 5'd1, 5'd7, 3'd3, 5'd9), 0, rvPkg::rkAlu, 5'd9, 32'd0, 0, 1, 0);
        addEntry(encR(7'h00, 5'd5, 5'd4, 3'd4, 5'd10), 0, rvPkg::rkAlu, 5'd10, 32'h22, 0, 1, 0);
        addEntry(encR(7'h00, 5'd1, 5'd10, 3'd6, 5'd11), 0, rvPkg::rkAlu, 5'd11, 32'h27, 0, 1, 0);
        addEntry(encR(7'h00, 5'd4, 5'd11, 3'd7, 5'd12), 0, rvPkg::rkAlu, 5'd12, 32'h20, 0, 1, 0);
        // Upper immediates and jumps
        addEntry(encU(20'h12345, 5'd13, 7'h37), 0, rvPkg::rkAlu, 5'd13, 32'h12345000, 0, 1, 0);
        addEntry(encU(20'h00001, 5'd14, 7'h17), 0, rvPkg::rkAlu, 5'd14, 32'h1134, 0, 1, 0);
        addEntry(encJ(21'd16, 5'd15), 1, rvPkg::rkJump, 5'd15, 32'h13c, 32'h148, 1, 1);
        addEntry(encI(12'd7, 5'd1, 3'd0, 5'd16, 7'h67), 0, rvPkg::rkJump, 5'd16, 32'h140,
                 32'h0c, 1, 1);
        // Every branch type, taken then not taken
        addEntry(encB(13'd8, 5'd3, 5'd1, 3'd0), 1, rvPkg::rkBranch, 0, 0, 32'h148, 0, 1);
        addEntry(encB(13'd8, 5'd2, 5'd1, 3'd0), 0, rvPkg::rkBranch, 0, 0, 32'h14c, 0, 0);
        addEntry(encB(13'h1ff8, 5'd2, 5'd1, 3'd1), 0, rvPkg::rkBranch, 0, 0, 32'h140, 0, 1);
        addEntry(encB(13'd12, 5'd3, 5'd1, 3'd1), 1, rvPkg::rkBranch, 0, 0, 32'h158, 0, 0);
        addEntry(encB(13'd16, 5'd1, 5'd7, 3'd4), 1, rvPkg::rkBranch, 0, 0, 32'h160, 0, 1);
        addEntry(encB(13'd16, 5'd7, 5'd1, 3'd4), 0, rvPkg::rkBranch, 0, 0, 32'h164, 0, 0);
        addEntry(encB(13'd4, 5'd7, 5'd1, 3'd5), 1, rvPkg::rkBranch, 0, 0, 32'h15c, 0, 1);
        addEntry(encB(13'd4, 5'd1, 5'd7, 3'd5), 0, rvPkg::rkBranch, 0, 0, 32'h160, 0, 0);
        addEntry(encB(13'd20, 5'd7, 5'd1, 3'd6), 0, rvPkg::rkBranch, 0, 0, 32'h174, 0, 1);
        addEntry(encB(13'd20, 5'd1, 5'd7, 3'd6), 0, rvPkg::rkBranch, 0, 0, 32'h178, 0, 0);
        addEntry(encB(13'h1ffc, 5'd1, 5'd7, 3'd7), 1, rvPkg::rkBranch, 0, 0, 32'h164, 0, 1);
        addEntry(encB(13'h1ffc, 5'd7, 5'd1, 3'd7), 0, rvPkg::rkBranch, 0, 0, 32'h168, 0, 0);
        // Memory ops, x0 and illegal encodings
        addEntry(encI(12'd8, 5'd4, 3'd2, 5'd20, 7'h03), 0, rvPkg::rkLoad, 5'd20, 0, 32'h30, 0, 0);
        addEntry(encR(7'h00, 5'd1, 5'd20, 3'd0, 5'd21), 0, rvPkg::rkAlu, 5'd21, 32'd5, 0, 1, 0);
        addEntry(encS(12'hffc, 5'd11, 5'd2, 3'd2), 0, rvPkg::rkStore, 0, 32'h27, 32'h6, 0, 0);
        addEntry(encI(12'd9, 5'd1, 3'd0, 5'd0, 7'h13), 0, rvPkg::rkAlu, 5'd0, 32'd14, 0, 0, 0);
        addEntry(encR(7'h00, 5'd1, 5'd0, 3'd0, 5'd22), 0, rvPkg::rkAlu, 5'd22, 32'd5, 0, 1, 0);
        addEntry(32'hffffffff, 0, rvPkg::rkIllegal, 0, 0, 0, 0, 0);
        addEntry(32'h00000073, 0, rvPkg::rkIllegal, 0, 0, 0, 0, 0);

        repeat (10) @(posedge clk);
        #2 rst = 1'b0;
        for (int i = 0; i < NumTests; i++) begin
            while (rvPkg::InDepth + creditsGot - sentInst == 0) begin
                instValid = 1'b0;
                expValid = 1'b0;
                @(posedge clk);
                #2;
            end
            instValid = 1'b1;
            instData.inst = instArr[i];
            instData.pc = expArr[i].pc;
            instData.pd = pdArr[i];
            expValid = 1'b1;
            expData = expArr[i];
            sentInst++;
            @(posedge clk);
            #2;
        end
        instValid = 1'b0;
        expValid = 1'b0;
        while (checked < NumTests) @(posedge clk);
        // Extra time lets any surplus result show up
        repeat (20) @(posedge clk);
        $display("Results checked %0d of %0d, errors %0d", checked, NumTests, errors);
        if (errors == 0 && checked == NumTests) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Downstream returns one credit per result after a random wait
    initial begin
        int delay;
        bit held;
        held = 1'b0;
        holding = 1'b0;
        resCredit = 1'b0;
        repeat (11) @(posedge clk);
        #2;
        forever begin
            if (!held && resultsSeen >= 12) begin
                held = 1'b1;
                holding = 1'b1;
                repeat (40) @(posedge clk);
                #2;
                holding = 1'b0;
            end
            if (resultsSeen > creditsReturned) begin
                delay = int'($urandom_range(4, 0));
                repeat (delay) begin
                    @(posedge clk);
                    #2;
                end
                resCredit = 1'b1;
                creditsReturned++;
                @(posedge clk);
                #2;
                resCredit = 1'b0;
            end else begin
                @(posedge clk);
                #2;
            end
        end
    end

    initial begin
        repeat (NumTests * 60 + 2000) @(posedge clk);
        $display("Timeout: not every instruction produced its result in time");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule
